/* design/dinoGame_macros.svh */
`ifndef DINOGAME_MACROS_SVH
`define DINOGAME_MACROS_SVH

// Screen size, last valid coordinate on each axis.
`define X_MAX 159
`define Y_MAX 119

// Dinosaur rectangle. Columns are [DINO_LEFT, DINO_RIGHT).
`define DINO_LEFT 15
`define DINO_RIGHT 25
`define DINO_H 12

// Obstacle geometry.
`define OBS_W 12
`define MIN_OBS_H 7
`define MAX_OBS_H 14
`define OBS1_START 120
`define OBS2_START 254

// First row of the ground strip.
`define GROUND_TOP 105
`define DINO_GROUND (`GROUND_TOP - `DINO_H)   // Dino top row when standing.

// Jump physics, in pixels per frame.
`define JUMP_RISE 20
`define FALL_STEP 2

// Obstacles step once every (STEP_BASE - speed) frames.
`define STEP_BASE 4

// Colour codes.
`define COL_BG 3'd3
`define COL_DINO 3'd2
`define COL_OBS1 3'd4
`define COL_OBS2 3'd5
`define COL_GRND 3'd6

`endif

/* design/dinoGamePkg.sv */
package dinoGamePkg;

    typedef logic [7:0] pixelCoord_t;   // Screen coordinate or obstacle size.
    typedef logic [3:0] bcdDigit_t;     // One decimal digit, 0 to 9.
    typedef logic [6:0] segments_t;     // Active low, bit 0 is segment a.
    typedef logic [2:0] pixelColor_t;

    // Game state as seen by the rest of the design.
    typedef enum logic [1:0] {
        MENU,
        RUNNING,
        PAUSED,
        OVER
    } gameState_t;

    // Controller states, including the wait-for-release states.
    // Neighbouring states differ in one bit where possible.
    typedef enum logic [3:0] {
        CS_MENU         = 4'b0000,
        CS_MENU_WAIT    = 4'b0001,
        CS_RUNNING      = 4'b0011,
        CS_RUNNING_WAIT = 4'b0111,
        CS_PAUSED       = 4'b1111,
        CS_PAUSED_WAIT  = 4'b1011,
        CS_OVER         = 4'b0010,
        CS_OVER_WAIT1   = 4'b0110,
        CS_OVER_WAIT2   = 4'b0100
    } controlState_t;

endpackage

/* design/gameControl.sv */
`timescale 1ns/1ps

module gameControl import dinoGamePkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       jump,
    input  logic       pause,
    input  logic       collision,
    output gameState_t gameState
);

    controlState_t state;
    controlState_t nextState;
    logic          start;

    assign start = jump || pause;   // Either button starts or resumes.

    always_comb begin
        nextState = state;
        case (state)
            CS_MENU:         nextState = start ? CS_MENU_WAIT : CS_MENU;
            CS_MENU_WAIT:    nextState = start ? CS_MENU_WAIT : CS_RUNNING;
            CS_RUNNING: begin
                if (collision)
                    nextState = CS_OVER;
                else if (pause)
                    nextState = CS_RUNNING_WAIT;
            end
            // Still running until pause is let go.
            CS_RUNNING_WAIT: begin
                if (collision)
                    nextState = CS_OVER;
                else if (!pause)
                    nextState = CS_PAUSED;
            end
            CS_PAUSED:       nextState = start ? CS_PAUSED_WAIT : CS_PAUSED;
            CS_PAUSED_WAIT:  nextState = start ? CS_PAUSED_WAIT : CS_RUNNING;
            CS_OVER:         nextState = start ? CS_OVER_WAIT1 : CS_OVER;
            CS_OVER_WAIT1:   nextState = start ? CS_OVER_WAIT1 : CS_OVER_WAIT2;
            CS_OVER_WAIT2:   nextState = CS_MENU;
            default:         nextState = CS_MENU;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            state <= CS_MENU;
        else
            state <= nextState;
    end

    // Collapse the wait states onto the visible state.
    always_comb begin
        case (state)
            CS_MENU, CS_MENU_WAIT:                     gameState = MENU;
            CS_RUNNING, CS_RUNNING_WAIT:               gameState = RUNNING;
            CS_PAUSED, CS_PAUSED_WAIT:                 gameState = PAUSED;
            CS_OVER, CS_OVER_WAIT1, CS_OVER_WAIT2:     gameState = OVER;
            default:                                   gameState = MENU;
        endcase
    end

    // A game can only end after it has been running.
    menuNeverToOver: assert property (
        @(posedge clk) disable iff (!resetn)
        gameState == MENU |=> gameState != OVER
    );

endmodule

/* design/gamePhysics.sv */
`timescale 1ns/1ps
`include "dinoGame_macros.svh"

module gamePhysics import dinoGamePkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        jump,
    input  logic        frameTick,
    input  gameState_t  gameState,
    input  bcdDigit_t   thousands,
    input  bcdDigit_t   tenThousands,
    input  bcdDigit_t   hundredThousands,
    output pixelCoord_t dinoY,
    output pixelCoord_t obs1X,
    output pixelCoord_t obs1H,
    output pixelCoord_t obs2X,
    output pixelCoord_t obs2H,
    output logic        collision,
    output logic        scoreTick
);

    logic [1:0]  speed;
    logic [1:0]  skipLimit;
    logic [1:0]  skipCount;     // Frames since the last obstacle step.
    logic        stepDue;
    logic        onGround;
    logic        active;
    pixelCoord_t nearX;
    pixelCoord_t nearH;
    pixelCoord_t nearRight;
    pixelCoord_t nearTop;
    logic        hitColumns;
    logic        hitRows;

    // Faster obstacles as the score grows.
    always_comb begin
        if (tenThousands != 4'd0 || hundredThousands != 4'd0)
            speed = 2'd3;
        else if (thousands != 4'd0)
            speed = 2'd2;
        else
            speed = 2'd1;
    end

    assign skipLimit = 2'(`STEP_BASE - 1 - speed);
    assign stepDue   = skipCount >= skipLimit;   // Also catches a speed-up mid count.
    assign active    = frameTick && gameState == RUNNING;
    assign scoreTick = active && stepDue;
    assign onGround  = dinoY == pixelCoord_t'(`DINO_GROUND);

    // Pick the nearer obstacle that has not yet passed the dinosaur.
    always_comb begin
        if (obs1X < obs2X && obs1X >= pixelCoord_t'(`DINO_LEFT - `OBS_W)) begin
            nearX = obs1X;
            nearH = obs1H;
        end else begin
            nearX = obs2X;
            nearH = obs2H;
        end
    end

    assign nearRight  = nearX + pixelCoord_t'(`OBS_W - 1);   // Last obstacle column.
    assign nearTop    = pixelCoord_t'(`GROUND_TOP) - nearH;
    assign hitColumns = (nearX >= `DINO_LEFT && nearX < `DINO_RIGHT) ||
                        (nearRight >= `DINO_LEFT && nearRight < `DINO_RIGHT);
    assign hitRows    = nearTop >= dinoY && nearTop < dinoY + `DINO_H;

    always_ff @(posedge clk) begin
        if (!resetn || gameState == MENU) begin
            dinoY     <= pixelCoord_t'(`DINO_GROUND);
            obs1X     <= pixelCoord_t'(`OBS1_START);
            obs1H     <= pixelCoord_t'(`MIN_OBS_H);
            obs2X     <= pixelCoord_t'(`OBS2_START);
            obs2H     <= pixelCoord_t'(`MAX_OBS_H);
            skipCount <= 2'd0;
            collision <= 1'b0;
        end else if (active) begin
            // Positions from before this step decide the hit.
            collision <= hitColumns && hitRows;

            if (onGround) begin
                if (jump)
                    dinoY <= dinoY - pixelCoord_t'(`JUMP_RISE);
            end else if (dinoY + `FALL_STEP >= `DINO_GROUND) begin
                dinoY <= pixelCoord_t'(`DINO_GROUND);   // Land exactly on the ground.
            end else begin
                dinoY <= dinoY + pixelCoord_t'(`FALL_STEP);
            end

            if (stepDue) begin
                skipCount <= 2'd0;
                obs1X     <= obs1X - 8'd1;   // Wraps modulo 256.
                obs2X     <= obs2X - 8'd1;
            end else begin
                skipCount <= skipCount + 2'd1;
            end
        end
    end

    // The dinosaur never sinks into the ground.
    dinoAboveGround: assert property (
        @(posedge clk) disable iff (!resetn)
        dinoY <= pixelCoord_t'(`DINO_GROUND)
    );

endmodule

/* design/bcdDigit.sv */
`timescale 1ns/1ps

module bcdDigit import dinoGamePkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      clear,
    input  logic      carryIn,
    output bcdDigit_t digit,
    output logic      carryOut
);

    logic atNine;

    assign atNine   = digit == 4'd9;
    assign carryOut = carryIn && atNine;   // Ripples through in one cycle.

    always_ff @(posedge clk) begin
        if (!resetn || clear)
            digit <= 4'd0;
        else if (carryIn)
            digit <= atNine ? 4'd0 : digit + 4'd1;
    end

    // Only decimal values ever appear.
    digitIsDecimal: assert property (
        @(posedge clk) disable iff (!resetn)
        digit <= 4'd9
    );

endmodule

/* design/scoreDisplay.sv */
`timescale 1ns/1ps

module scoreDisplay import dinoGamePkg::*; (
    input  bcdDigit_t ones,
    input  bcdDigit_t tens,
    input  bcdDigit_t hundreds,
    input  bcdDigit_t thousands,
    input  bcdDigit_t tenThousands,
    input  bcdDigit_t hundredThousands,
    output segments_t hex0,
    output segments_t hex1,
    output segments_t hex2,
    output segments_t hex3,
    output segments_t hex4,
    output segments_t hex5
);

    // Segment order is gfedcba, a lit segment is 0.
    function automatic segments_t decode(input bcdDigit_t value);
        case (value)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            default: return 7'b1111111;   // Blank.
        endcase
    endfunction

    assign hex0 = decode(ones);
    assign hex1 = decode(tens);
    assign hex2 = decode(hundreds);
    assign hex3 = decode(thousands);
    assign hex4 = decode(tenThousands);
    assign hex5 = decode(hundredThousands);

endmodule

/* design/frameRenderer.sv */
`timescale 1ns/1ps
`include "dinoGame_macros.svh"

module frameRenderer import dinoGamePkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  pixelCoord_t dinoY,
    input  pixelCoord_t obs1X,
    input  pixelCoord_t obs1H,
    input  pixelCoord_t obs2X,
    input  pixelCoord_t obs2H,
    output pixelCoord_t x,
    output pixelCoord_t y,
    output pixelColor_t color,
    output logic        frameTick
);

    pixelCoord_t nextX;
    pixelCoord_t nextY;
    logic        lastPixel;

    // Obstacle box. Compared wide so that a right edge past 255 does not wrap.
    function automatic logic inObstacle(input pixelCoord_t px, input pixelCoord_t py,
                                        input pixelCoord_t ox, input pixelCoord_t oh);
        return px >= ox && px < ox + `OBS_W && py >= `GROUND_TOP - oh;
    endfunction

    function automatic pixelColor_t pickColor(input pixelCoord_t px, input pixelCoord_t py);
        if (py >= `GROUND_TOP)
            return `COL_GRND;
        else if (px >= `DINO_LEFT && px < `DINO_RIGHT && py >= dinoY && py < dinoY + `DINO_H)
            return `COL_DINO;
        else if (inObstacle(px, py, obs1X, obs1H))
            return `COL_OBS1;
        else if (inObstacle(px, py, obs2X, obs2H))
            return `COL_OBS2;
        else
            return `COL_BG;
    endfunction

    assign lastPixel = x == pixelCoord_t'(`X_MAX) && y == pixelCoord_t'(`Y_MAX);

    // Raster order. Left to right, then top to bottom.
    always_comb begin
        if (x == pixelCoord_t'(`X_MAX)) begin
            nextX = 8'd0;
            nextY = (y == pixelCoord_t'(`Y_MAX)) ? 8'd0 : y + 8'd1;
        end else begin
            nextX = x + 8'd1;
            nextY = y;
        end
    end

    // Colour is worked out for the coordinates it is registered with.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            x         <= 8'd0;
            y         <= 8'd0;
            color     <= `COL_BG;   // Pixel (0,0) is always sky.
            frameTick <= 1'b0;
        end else begin
            x         <= nextX;
            y         <= nextY;
            color     <= pickColor(nextX, nextY);
            frameTick <= lastPixel;   // High while (0,0) is shown.
        end
    end

endmodule

/* design/dinoGame.sv */
`timescale 1ns/1ps

module dinoGame import dinoGamePkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        jump,
    input  logic        pause,
    output logic        running,
    output gameState_t  gameState,
    output segments_t   hex0,
    output segments_t   hex1,
    output segments_t   hex2,
    output segments_t   hex3,
    output segments_t   hex4,
    output segments_t   hex5,
    output pixelCoord_t x,
    output pixelCoord_t y,
    output pixelColor_t color
);

    logic        frameTick;
    logic        collision;
    logic        scoreTick;
    logic        scoreClear;
    logic [6:0]  carry;         // carry[i] feeds digit i.
    bcdDigit_t   digits [6];    // digits[0] is the ones digit.
    pixelCoord_t dinoY;
    pixelCoord_t obs1X;
    pixelCoord_t obs1H;
    pixelCoord_t obs2X;
    pixelCoord_t obs2H;

    assign running    = gameState == RUNNING;   // LED.
    assign scoreClear = gameState == MENU;
    assign carry[0]   = scoreTick;

    gameControl control (
        .clk, .resetn, .jump, .pause, .collision, .gameState
    );

    gamePhysics physics (
        .clk, .resetn, .jump, .frameTick, .gameState,
        .thousands(digits[3]), .tenThousands(digits[4]), .hundredThousands(digits[5]),
        .dinoY, .obs1X, .obs1H, .obs2X, .obs2H, .collision, .scoreTick
    );

    // Score counter as a ripple of decimal stages.
    for (genvar i = 0; i < 6; i++) begin : gScore
        bcdDigit stage (
            .clk, .resetn,
            .clear(scoreClear),
            .carryIn(carry[i]),
            .digit(digits[i]),
            .carryOut(carry[i+1])
        );
    end

    scoreDisplay display (
        .ones(digits[0]), .tens(digits[1]), .hundreds(digits[2]),
        .thousands(digits[3]), .tenThousands(digits[4]), .hundredThousands(digits[5]),
        .hex0, .hex1, .hex2, .hex3, .hex4, .hex5
    );

    frameRenderer renderer (
        .clk, .resetn, .dinoY, .obs1X, .obs1H, .obs2X, .obs2H,
        .x, .y, .color, .frameTick
    );

    // The score never rolls over.
    scoreNeverRollsOver: assert property (
        @(posedge clk) disable iff (!resetn)
        scoreTick |-> !carry[6]
    );

endmodule

/* test/dinoGameTb.sv */
`timescale 1ns/1ps
`include "dinoGame_macros.svh"

module dinoGameTb import dinoGamePkg::*;;

    localparam int FRAME_CYCLES    = (`X_MAX + 1) * (`Y_MAX + 1);
    localparam int TIMEOUT_CYCLES  = 400 * FRAME_CYCLES;
    localparam int FRAMES_PER_STEP = 3;     // Speed 1 while the score stays below 1000.
    localparam int MAX_RUN_FRAMES  = 300;
    localparam segments_t SEG_ZERO = 7'b1000000;

    logic        clk;
    logic        resetn;
    logic        jump;
    logic        pause;
    logic        running;
    gameState_t  gameState;
    segments_t   hex0, hex1, hex2, hex3, hex4, hex5;
    pixelCoord_t x;
    pixelCoord_t y;
    pixelColor_t color;

    int unsigned cycles = 0;
    int unsigned rngState;
    int          runFrames;        // Frame ticks seen while running.
    int          scoreValue;
    int          expectedScore;
    int          expectedObs1X;
    logic        anyBlank;
    logic        frameStart;
    logic        dinoGrounded;     // No jump seen in this game.

    dinoGame UUT (
        .clk, .resetn, .jump, .pause, .running, .gameState,
        .hex0, .hex1, .hex2, .hex3, .hex4, .hex5, .x, .y, .color
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Active-low gfedcba. A pattern that is no digit maps to 15.
    function automatic int segmentValue(input segments_t seg);
        case (seg)
            7'b1000000: return 0;
            7'b1111001: return 1;
            7'b0100100: return 2;
            7'b0110000: return 3;
            7'b0011001: return 4;
            7'b0010010: return 5;
            7'b0000010: return 6;
            7'b1111000: return 7;
            7'b0000000: return 8;
            7'b0010000: return 9;
            default:    return 15;
        endcase
    endfunction

    function automatic int unsigned nextRandom(input int unsigned s);
        int unsigned r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        return r ^ (r << 5);
    endfunction

    task automatic reportMismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] expected);
        $display("FAIL %s got 0x%0h expected 0x%0h", name, got, expected);
        $display("RESULT: FAIL");
        $fatal(1, "check on %s failed", name);
    endtask

    task automatic reportProblem(input string what);
        $display("Error: %s", what);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    always_comb begin
        scoreValue = segmentValue(hex0) + 10 * segmentValue(hex1) +
                     100 * segmentValue(hex2) + 1000 * segmentValue(hex3) +
                     10000 * segmentValue(hex4) + 100000 * segmentValue(hex5);
        anyBlank = segmentValue(hex0) > 9 || segmentValue(hex1) > 9 ||
                   segmentValue(hex2) > 9 || segmentValue(hex3) > 9 ||
                   segmentValue(hex4) > 9 || segmentValue(hex5) > 9;
    end

    assign frameStart    = x == 8'd0 && y == 8'd0;   // Frame tick goes with pixel (0,0).
    assign expectedScore = runFrames / FRAMES_PER_STEP;
    assign expectedObs1X = `OBS1_START - expectedScore;

    // Reference model of the obstacle steps.
    always @(posedge clk) begin
        if (!resetn || gameState == MENU) begin
            runFrames    <= 0;
            dinoGrounded <= 1'b1;
        end else if (gameState == RUNNING) begin
            if (frameStart)
                runFrames <= runFrames + 1;
            if (jump)
                dinoGrounded <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            reportProblem("the run went past its cycle limit");
    end

    resetToMenu: assert property (@(posedge clk) !resetn |=> gameState == MENU && !running)
        else reportMismatch("gameState", $sampled(gameState), MENU);
    resetShowsZero: assert property (@(posedge clk)
        !resetn |=> {hex5, hex4, hex3, hex2, hex1, hex0} == {6{SEG_ZERO}})
        else reportMismatch("hex", $sampled({hex5, hex4, hex3, hex2, hex1, hex0}),
                            {6{SEG_ZERO}});
    ledFollowsState: assert property (@(posedge clk) disable iff (!resetn)
        running == (gameState == RUNNING))
        else reportMismatch("running", $sampled(running), $sampled(gameState) == RUNNING);

    startFromMenu: assert property (@(posedge clk) disable iff (!resetn)
        $fell(jump || pause) && gameState == MENU |=> gameState == RUNNING)
        else reportMismatch("gameState", $sampled(gameState), RUNNING);
    pauseFromRunning: assert property (@(posedge clk) disable iff (!resetn)
        $fell(pause) && gameState == RUNNING |=> gameState == PAUSED)
        else reportMismatch("gameState", $sampled(gameState), PAUSED);
    resumeFromPaused: assert property (@(posedge clk) disable iff (!resetn)
        $fell(jump || pause) && gameState == PAUSED |=> gameState == RUNNING)
        else reportMismatch("gameState", $sampled(gameState), RUNNING);
    // Release seen one cycle ago, so the last wait state is showing.
    overToMenu: assert property (@(posedge clk) disable iff (!resetn)
        gameState == OVER && $past(jump || pause, 2) && !$past(jump || pause)
        |=> gameState == MENU)
        else reportMismatch("gameState", $sampled(gameState), MENU);

    // The last reset clock still leaves x at 0.
    rasterStep: assert property (@(posedge clk) disable iff (!resetn)
        resetn && x != `X_MAX |=> x == $past(x) + 8'd1 && y == $past(y))
        else reportMismatch("x", $sampled(x), $past(x) + 8'd1);
    rasterWrap: assert property (@(posedge clk) disable iff (!resetn)
        x == `X_MAX |=> x == 8'd0 && y == ($past(y) == `Y_MAX ? 8'd0 : $past(y) + 8'd1))
        else reportMismatch("y", $sampled(y), $past(y) == `Y_MAX ? 8'd0 : $past(y) + 8'd1);
    groundColor: assert property (@(posedge clk) disable iff (!resetn)
        y >= `GROUND_TOP |-> color == `COL_GRND)
        else reportMismatch("color", $sampled(color), `COL_GRND);
    dinoColor: assert property (@(posedge clk) disable iff (!resetn)
        dinoGrounded && x >= `DINO_LEFT && x < `DINO_RIGHT &&
        y >= `GROUND_TOP - `DINO_H && y < `GROUND_TOP |-> color == `COL_DINO)
        else reportMismatch("color", $sampled(color), `COL_DINO);

    digitsDecimal: assert property (@(posedge clk) disable iff (!resetn) !anyBlank)
        else reportProblem($sformatf("segment outputs 0x%0h do not all show a digit",
                                     $sampled({hex5, hex4, hex3, hex2, hex1, hex0})));
    scoreFollowsSteps: assert property (@(posedge clk) disable iff (!resetn)
        scoreValue == expectedScore)
        else reportMismatch("score", $sampled(scoreValue), $sampled(expectedScore));
    scoreNeverDrops: assert property (@(posedge clk) disable iff (!resetn)
        gameState == RUNNING |=> scoreValue >= $past(scoreValue))
        else reportMismatch("score", $sampled(scoreValue), $past(scoreValue));
    scoreFrozenOver: assert property (@(posedge clk) disable iff (!resetn)
        gameState == OVER |=> scoreValue == $past(scoreValue))
        else reportMismatch("score", $sampled(scoreValue), $past(scoreValue));
    scoreClearsInMenu: assert property (@(posedge clk) disable iff (!resetn)
        gameState == MENU |=> scoreValue == 0)
        else reportMismatch("score", $sampled(scoreValue), 0);

    overInTime: assert property (@(posedge clk) disable iff (!resetn)
        gameState == RUNNING |-> runFrames < MAX_RUN_FRAMES)
        else reportProblem("the game did not end within 300 running frames");
    overAtObstacle: assert property (@(posedge clk) disable iff (!resetn)
        $rose(gameState == OVER) |->
        expectedObs1X < `DINO_RIGHT && expectedObs1X + `OBS_W > `DINO_LEFT)
        else reportProblem("the game ended while obstacle 1 was away from the dinosaur");

    // Held for one to three clocks.
    task automatic pressButton(input logic useJump);
        int unsigned hold;
        rngState = nextRandom(rngState);
        hold = 1 + rngState % 3;
        @(posedge clk);
        if (useJump)
            jump <= 1'b1;
        else
            pause <= 1'b1;
        repeat (hold) @(posedge clk);
        jump  <= 1'b0;
        pause <= 1'b0;
    endtask

    task automatic waitForState(input gameState_t target);
        while (gameState != target)
            @(negedge clk);
    endtask

    task automatic waitForFrames(input int count);
        repeat (count) begin
            do
                @(negedge clk);
            while (!frameStart);
        end
    endtask

    initial begin
        resetn   = 1'b0;
        jump     = 1'b0;
        pause    = 1'b0;
        rngState = 32'd57810;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        repeat (5) @(posedge clk);

        pressButton(1'b1);
        waitForState(RUNNING);
        while (runFrames < 10)
            @(negedge clk);
        pressButton(1'b0);
        waitForState(PAUSED);
        waitForFrames(3);
        pressButton(1'b1);   // Resume.
        waitForState(RUNNING);

        waitForState(OVER);   // No jumps, so obstacle 1 hits.
        waitForFrames(2);
        pressButton(1'b1);
        waitForState(MENU);
        waitForFrames(1);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* sources.f */
+incdir+design
design/dinoGamePkg.sv
design/gameControl.sv
design/gamePhysics.sv
design/bcdDigit.sv
design/scoreDisplay.sv
design/frameRenderer.sv
design/dinoGame.sv
test/dinoGameTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module dinoGameTb -Mdir obj_dir -o dinoGameSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dinoGameSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi
exit 0
